// File: alu_cfg_pkg.sv
/*
 * Word and float format of the arithmetic unit.
 * Float layout: sign, 8-bit two's-complement exponent, 23-bit mantissa,
 * no hidden bit. Every RTL block takes its widths from here.
 */
`default_nettype none

package alu_cfg_pkg;

	// ************************************************************************
	// Widths
	// ************************************************************************

	localparam int WORD_W = 32;  // Operand and result word
	localparam int EXP_W  = 8;   // Signed exponent field
	localparam int MAN_W  = 23;  // Mantissa field, no hidden bit

	// Divisor for NRM and NRM_M
	localparam int NRM_GAIN = 64;

	// ************************************************************************
	// Types
	// ************************************************************************

	typedef logic        [WORD_W-1:0] word_t;
	typedef logic signed [EXP_W-1:0]  exp_t;
	typedef logic        [MAN_W-1:0]  man_t;

	// Exponent given to a normalized zero mantissa
	localparam exp_t EXP_MIN = {1'b1, {(EXP_W-1){1'b0}}};

	// Overlays one word_t, sign in the top bit
	typedef struct packed {
		logic sign;
		exp_t exp;
		man_t man;
	} flt_t;

endpackage

`default_nettype wire

// File: alu_op_pkg.sv
/*
 * Opcode encoding and the request and result records of the unit.
 * Opcode numbers follow the processor's instruction set; gaps are illegal.
 */
`default_nettype none

package alu_op_pkg;

	import alu_cfg_pkg::*;

	// Gaps at 7, 14, 18, 21, 22, 26, 28, 33 and 42 return zero
	typedef enum logic [5:0] {
		OP_NOP   = 6'd0,  OP_LOD   = 6'd1,
		OP_ADD   = 6'd2,  OP_F_ADD = 6'd3,
		OP_MLT   = 6'd4,  OP_F_MLT = 6'd5,
		OP_DIV   = 6'd6,  OP_MOD   = 6'd8,
		OP_SGN   = 6'd9,  OP_F_SGN = 6'd10,
		OP_NEG   = 6'd11, OP_NEG_M = 6'd12, OP_F_NEG = 6'd13,
		OP_ABS   = 6'd15, OP_ABS_M = 6'd16, OP_F_ABS = 6'd17,
		OP_PST   = 6'd19, OP_PST_M = 6'd20,
		OP_NRM   = 6'd23, OP_NRM_M = 6'd24,
		OP_I2F   = 6'd25, OP_F2I   = 6'd27,
		OP_AND   = 6'd29, OP_ORR   = 6'd30, OP_XOR   = 6'd31,
		OP_INV   = 6'd32,
		OP_LAN   = 6'd34, OP_LOR   = 6'd35,
		OP_LES   = 6'd36, OP_F_LES = 6'd37,
		OP_GRE   = 6'd38, OP_F_GRE = 6'd39,
		OP_EQU   = 6'd40, OP_LIN   = 6'd41,
		OP_SHL   = 6'd43, OP_SHR   = 6'd44, OP_SRS   = 6'd45
	} alu_op_e;

	// a is the memory operand, b the accumulator
	typedef struct packed {
		alu_op_e op;
		word_t   a;
		word_t   b;
	} alu_req_t;

	typedef struct packed {
		word_t value;
		logic  is_zero;
	} alu_res_t;

	// Result of one unit, valid only for the opcodes it owns
	typedef struct packed {
		logic  valid;
		word_t value;
	} unit_out_t;

	// Float-producing ops whose result goes through normalization
	function automatic logic needs_norm(input alu_op_e op);
		return op inside {OP_I2F, OP_F_ADD, OP_F_MLT};
	endfunction

endpackage

`default_nettype wire

// File: int_unit.sv
/*
 * Integer side of the unit: arithmetic, bitwise, logical, compare and shift.
 * Purely combinational. Claims its opcodes through res.valid.
 */
`timescale 1ns/1ps
`default_nettype none

module int_unit (
	input  wire alu_op_pkg::alu_req_t req,
	output alu_op_pkg::unit_out_t     res
);

	import alu_cfg_pkg::*;
	import alu_op_pkg::*;

	// ************************************************************************
	// Helpers shared by the b and a (_M) forms
	// ************************************************************************

	function automatic word_t abs_w(input word_t x);
		return x[WORD_W-1] ? -x : x;
	endfunction

	// Negative values clamp to zero
	function automatic word_t pst_w(input word_t x);
		return x[WORD_W-1] ? '0 : x;
	endfunction

	// Signed division by the fixed gain
	function automatic word_t nrm_w(input word_t x);
		return word_t'(signed'(x) / NRM_GAIN);
	endfunction

	logic signed [WORD_W-1:0] a_s;  // Memory operand
	logic signed [WORD_W-1:0] b_s;  // Accumulator
	logic                     a_nz;
	logic                     b_nz;
	word_t                    sgn_val;

	assign a_s  = req.a;
	assign b_s  = req.b;
	assign a_nz = (req.a != '0);
	assign b_nz = (req.b != '0);

	// b keeps its magnitude, takes the sign relation of a
	assign sgn_val = (req.a[WORD_W-1] == req.b[WORD_W-1]) ? req.b : -req.b;

	// ************************************************************************
	// Result select
	// ************************************************************************

	always_comb begin
		res.valid = 1'b1;
		res.value = '0;
		case (req.op)
			// Pass
			OP_NOP:   res.value = req.b;
			OP_LOD:   res.value = req.a;

			// Arithmetic
			OP_ADD:   res.value = word_t'(a_s + b_s);
			OP_MLT:   res.value = word_t'(a_s * b_s);
			OP_DIV:   res.value = word_t'(a_s / b_s);
			OP_MOD:   res.value = word_t'(a_s % b_s);
			OP_NEG:   res.value = -req.b;
			OP_NEG_M: res.value = -req.a;
			OP_ABS:   res.value = abs_w(req.b);
			OP_ABS_M: res.value = abs_w(req.a);
			OP_PST:   res.value = pst_w(req.b);
			OP_PST_M: res.value = pst_w(req.a);
			OP_SGN:   res.value = sgn_val;
			OP_NRM:   res.value = nrm_w(req.b);
			OP_NRM_M: res.value = nrm_w(req.a);

			// Bitwise
			OP_AND:   res.value = req.a & req.b;
			OP_ORR:   res.value = req.a | req.b;
			OP_XOR:   res.value = req.a ^ req.b;
			OP_INV:   res.value = ~req.b;

			// Logical, 0 or 1
			OP_LAN:   res.value = word_t'(a_nz && b_nz);
			OP_LOR:   res.value = word_t'(a_nz || b_nz);
			OP_LIN:   res.value = word_t'(!b_nz);

			// Signed compares
			OP_LES:   res.value = word_t'(a_s < b_s);
			OP_GRE:   res.value = word_t'(a_s > b_s);
			OP_EQU:   res.value = word_t'(req.a == req.b);

			// Shift amount is b as unsigned
			OP_SHL:   res.value = req.a << req.b;
			OP_SHR:   res.value = req.a >> req.b;
			OP_SRS:   res.value = word_t'(a_s >>> req.b);

			default:  res.valid = 1'b0;  // Float or illegal
		endcase
	end

endmodule

`default_nettype wire

// File: float_unit.sv
/*
 * Float side of the unit and the int/float conversions. Combinational.
 * F_ADD, F_MLT and I2F leave unnormalized results; the result stage fixes them.
 */
`timescale 1ns/1ps
`default_nettype none

module float_unit (
	input  wire alu_op_pkg::alu_req_t req,
	output alu_op_pkg::unit_out_t     res
);

	import alu_cfg_pkg::*;
	import alu_op_pkg::*;

	flt_t                     fa;        // a as float
	flt_t                     fb;        // b as float
	logic signed [EXP_W:0]    exp_diff;
	logic        [EXP_W:0]    sh_a;
	logic        [EXP_W:0]    sh_b;
	exp_t                     exp_al;    // Larger of the two exponents
	man_t                     al_a;
	man_t                     al_b;
	logic signed [MAN_W:0]    sm_a;      // Aligned, signed mantissas
	logic signed [MAN_W:0]    sm_b;
	logic signed [MAN_W+1:0]  add_sum;
	logic        [MAN_W+1:0]  add_mag;
	logic        [2*MAN_W-1:0] prod;
	flt_t                     add_f;
	flt_t                     mlt_f;
	flt_t                     i2f_f;
	word_t                    i2f_mag;
	logic signed [WORD_W-1:0] f2i_sm;
	logic        [EXP_W-1:0]  f2i_sh;
	word_t                    f2i_val;

	assign fa = req.a;
	assign fb = req.b;

	// ************************************************************************
	// Exponent alignment for F_ADD, F_LES and F_GRE
	// ************************************************************************

	always_comb begin
		exp_diff = fa.exp - fb.exp;
		if (exp_diff[EXP_W]) begin  // a has the smaller exponent
			sh_a   = -exp_diff;
			sh_b   = '0;
			exp_al = fb.exp;
		end else begin
			sh_a   = '0;
			sh_b   = exp_diff;
			exp_al = fa.exp;
		end
		al_a = fa.man >> sh_a;
		al_b = fb.man >> sh_b;
		sm_a = fa.sign ? -{1'b0, al_a} : {1'b0, al_a};
		sm_b = fb.sign ? -{1'b0, al_b} : {1'b0, al_b};
	end

	// Sum carries one extra bit, so the exponent goes up by one
	always_comb begin
		add_sum    = sm_a + sm_b;
		add_mag    = add_sum[MAN_W+1] ? -add_sum : add_sum;
		add_f.sign = add_sum[MAN_W+1];
		add_f.exp  = exp_al + exp_t'(1);
		add_f.man  = add_mag[MAN_W:1];
	end

	// Top half of the mantissa product
	always_comb begin
		prod       = fa.man * fb.man;
		mlt_f.sign = fa.sign ^ fb.sign;
		mlt_f.exp  = exp_t'(fa.exp + fb.exp + MAN_W);
		mlt_f.man  = prod[2*MAN_W-1:MAN_W];
	end

	// ************************************************************************
	// Conversions
	// ************************************************************************

	// Integer assumed to fit the mantissa range, sign taken at its top bit
	always_comb begin
		i2f_f.sign = req.b[MAN_W-1];
		i2f_mag    = i2f_f.sign ? -req.b : req.b;
		i2f_f.exp  = '0;
		i2f_f.man  = i2f_mag[MAN_W-1:0];
	end

	always_comb begin
		f2i_sm = fb.sign ? -signed'(word_t'(fb.man)) : signed'(word_t'(fb.man));
		f2i_sh = fb.exp[EXP_W-1] ? -fb.exp : fb.exp;
		if (fb.exp[EXP_W-1])
			f2i_val = word_t'(f2i_sm >>> f2i_sh);  // Negative exponent
		else
			f2i_val = word_t'(f2i_sm << f2i_sh);
	end

	// ************************************************************************
	// Result select
	// ************************************************************************

	always_comb begin
		res.valid = 1'b1;
		res.value = '0;
		case (req.op)
			OP_F_ADD: res.value = add_f;
			OP_F_MLT: res.value = mlt_f;
			OP_F_NEG: res.value = {~fb.sign, fb.exp, fb.man};
			OP_F_ABS: res.value = {1'b0, fb.exp, fb.man};
			OP_F_SGN: res.value = {fa.sign, fb.exp, fb.man};
			OP_F_LES: res.value = word_t'(sm_a < sm_b);
			OP_F_GRE: res.value = word_t'(sm_a > sm_b);
			OP_I2F:   res.value = i2f_f;
			OP_F2I:   res.value = f2i_val;
			default:  res.valid = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: result_stage.sv
/*
 * Picks the owning unit's result, normalizes float-producing results
 * and registers value, zero flag and valid. One cycle of latency.
 */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  wire                         clk,
	input  wire                         rst_n,
	input  wire alu_op_pkg::alu_op_e    op,
	input  wire                         in_valid,
	input  wire alu_op_pkg::unit_out_t  int_res,
	input  wire alu_op_pkg::unit_out_t  flt_res,
	output alu_op_pkg::alu_res_t        res,
	output logic                        out_valid
);

	import alu_cfg_pkg::*;
	import alu_op_pkg::*;

	word_t            sel_value;
	flt_t             raw_f;
	flt_t             norm_f;
	logic [EXP_W-1:0] lead;         // Leading zeros of the mantissa
	word_t            final_value;

	// Zero when neither unit claims the opcode
	always_comb begin
		if (int_res.valid)
			sel_value = int_res.value;
		else if (flt_res.valid)
			sel_value = flt_res.value;
		else
			sel_value = '0;
	end

	assign raw_f = sel_value;

	// ************************************************************************
	// Normalization
	// ************************************************************************

	// Highest set bit wins, so the last hit in the scan sets the count
	always_comb begin
		lead = '0;
		for (int i = 0; i < MAN_W; i++) begin
			if (raw_f.man[i])
				lead = EXP_W'(MAN_W - 1 - i);
		end
		norm_f.sign = raw_f.sign;
		norm_f.man  = raw_f.man << lead;
		if (raw_f.man == '0)
			norm_f.exp = EXP_MIN;
		else
			norm_f.exp = raw_f.exp - exp_t'(lead);  // Wraps like the exponent field
	end

	assign final_value = needs_norm(op) ? word_t'(norm_f) : sel_value;

	// ************************************************************************
	// Output register
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			res       <= '0;
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				res.value   <= final_value;
				res.is_zero <= (final_value == '0);
			end
		end
	end

endmodule

`default_nettype wire

// File: alu_top.sv
/*
 * Top of the arithmetic unit. Integer and float units work side by side
 * on each request; the result stage answers one clock later.
 */
`timescale 1ns/1ps
`default_nettype none

module alu_top (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire                        in_valid,
	input  wire alu_op_pkg::alu_req_t  req,
	output alu_op_pkg::alu_res_t       res,
	output logic                       out_valid
);

	import alu_op_pkg::*;

	unit_out_t int_res;  // Integer unit result and ownership
	unit_out_t flt_res;  // Float unit result and ownership

	// ************************************************************************
	// Units
	// ************************************************************************

	int_unit u_int (
		.req (req),
		.res (int_res)
	);

	float_unit u_flt (
		.req (req),
		.res (flt_res)
	);

	// Select, normalize, register
	result_stage u_out (
		.clk       (clk),
		.rst_n     (rst_n),
		.op        (req.op),
		.in_valid  (in_valid),
		.int_res   (int_res),
		.flt_res   (flt_res),
		.res       (res),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: tb_alu.sv
/*
 * Self-checking testbench for the arithmetic unit. Drives one request per
 * cycle, predicts each result from the word and float format rules and
 * checks the registered output with concurrent assertions.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_alu;

	import alu_cfg_pkg::*;
	import alu_op_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int REPS         = 12;  // Random requests per opcode
	// Latency test, random opcodes, two idles per test, illegal stream
	localparam int STIM_CYCLES  = 6 + (15 + 13 + 4 + 5) * REPS + 4 * 2 + (2 * 11 + 2);
	localparam int CYCLE_LIMIT  = 2 * STIM_CYCLES + RESET_CYCLES;

	typedef struct packed {
		logic     valid;
		alu_res_t res;
	} expect_t;

	logic     clk;
	logic     rst_n;
	logic     in_valid;
	alu_req_t req;
	alu_res_t res;
	logic     out_valid;

	expect_t  exp_q[$];  // One entry per driven cycle
	alu_res_t exp_res;
	logic     exp_valid;

	int errors       = 0;
	int err_base     = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int cycle_count  = 0;

	alu_op_e int_ops [15] = '{OP_NOP, OP_LOD, OP_ADD, OP_MLT, OP_DIV, OP_MOD, OP_NEG,
		OP_NEG_M, OP_ABS, OP_ABS_M, OP_PST, OP_PST_M, OP_SGN, OP_NRM, OP_NRM_M};
	alu_op_e bit_ops [13] = '{OP_AND, OP_ORR, OP_XOR, OP_INV, OP_LAN, OP_LOR, OP_LIN,
		OP_LES, OP_GRE, OP_EQU, OP_SHL, OP_SHR, OP_SRS};
	alu_op_e fun_ops [4]  = '{OP_F_NEG, OP_F_ABS, OP_F_SGN, OP_I2F};
	alu_op_e far_ops [5]  = '{OP_F_ADD, OP_F_MLT, OP_F_LES, OP_F_GRE, OP_F2I};
	logic [5:0] illegal_codes [11] = '{6'd7, 6'd14, 6'd18, 6'd21, 6'd22, 6'd26,
		6'd28, 6'd33, 6'd42, 6'd46, 6'd63};

	alu_top u_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.req       (req),
		.res       (res),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ************************************************************************
	// Reference rules
	// ************************************************************************

	// Top mantissa bit set, exponent lowered by the shift
	function automatic word_t normalize(input word_t w);
		flt_t f;
		f = w;
		if (f.man == '0)
			f.exp = exp_t'(-128);  // Most negative exponent
		else
			while (!f.man[MAN_W-1]) begin
				f.man = f.man << 1;
				f.exp = f.exp - exp_t'(1);
			end
		return f;
	endfunction

	// Aligns to the larger exponent, returns it with signed mantissas
	function automatic int align(input flt_t x, input flt_t y, output int mx, output int my);
		int ex;
		int ey;
		ex = x.exp;
		ey = y.exp;
		mx = x.man;
		my = y.man;
		if (ex < ey)
			mx = mx >> (ey - ex);
		else
			my = my >> (ex - ey);
		if (x.sign)
			mx = -mx;
		if (y.sign)
			my = -my;
		return (ex < ey) ? ey : ex;
	endfunction

	function automatic alu_res_t ref_result(input alu_op_e op, input word_t a, input word_t b);
		int       sa;
		int       sb;
		int       mx;
		int       my;
		int       e;
		int       sum;
		longint   prod;
		flt_t     fa;
		flt_t     fb;
		flt_t     f;
		word_t    v;
		logic     norm;
		alu_res_t r;
		sa   = signed'(a);
		sb   = signed'(b);
		fa   = a;
		fb   = b;
		v    = '0;
		norm = 1'b0;
		case (op)
			OP_NOP:   v = b;
			OP_LOD:   v = a;
			OP_ADD:   v = sa + sb;
			OP_MLT:   v = sa * sb;
			OP_DIV:   v = sa / sb;
			OP_MOD:   v = sa % sb;
			OP_NEG:   v = -sb;
			OP_NEG_M: v = -sa;
			OP_ABS:   v = (sb < 0) ? -sb : sb;
			OP_ABS_M: v = (sa < 0) ? -sa : sa;
			OP_PST:   v = (sb < 0) ? 0 : sb;
			OP_PST_M: v = (sa < 0) ? 0 : sa;
			OP_SGN:   v = ((sa < 0) == (sb < 0)) ? sb : -sb;
			OP_NRM:   v = sb / NRM_GAIN;
			OP_NRM_M: v = sa / NRM_GAIN;
			OP_AND:   v = a & b;
			OP_ORR:   v = a | b;
			OP_XOR:   v = a ^ b;
			OP_INV:   v = ~b;
			OP_LAN:   v = (a != 0 && b != 0);
			OP_LOR:   v = (a != 0 || b != 0);
			OP_LIN:   v = (b == 0);
			OP_LES:   v = (sa < sb);
			OP_GRE:   v = (sa > sb);
			OP_EQU:   v = (a == b);
			OP_SHL:   v = a << b;
			OP_SHR:   v = a >> b;
			OP_SRS:   v = sa >>> b;
			OP_F_NEG: v = {~b[WORD_W-1], b[WORD_W-2:0]};
			OP_F_ABS: v = {1'b0, b[WORD_W-2:0]};
			OP_F_SGN: v = {a[WORD_W-1], b[WORD_W-2:0]};
			OP_F_LES: begin
				e = align(fa, fb, mx, my);
				v = (mx < my);
			end
			OP_F_GRE: begin
				e = align(fa, fb, mx, my);
				v = (mx > my);
			end
			OP_F_ADD: begin
				e      = align(fa, fb, mx, my);
				sum    = mx + my;
				f.sign = (sum < 0);
				f.man  = man_t'(((sum < 0) ? -sum : sum) >> 1);  // One bit of headroom
				f.exp  = exp_t'(e + 1);
				v      = f;
				norm   = 1'b1;
			end
			OP_F_MLT: begin
				prod   = longint'(fa.man) * longint'(fb.man);
				f.sign = fa.sign ^ fb.sign;
				f.man  = man_t'(prod >> MAN_W);
				f.exp  = exp_t'(int'(fa.exp) + int'(fb.exp) + MAN_W);
				v      = f;
				norm   = 1'b1;
			end
			OP_I2F: begin
				f.sign = (sb < 0);
				f.exp  = '0;
				f.man  = man_t'((sb < 0) ? -sb : sb);
				v      = f;
				norm   = 1'b1;
			end
			OP_F2I: begin
				mx = fb.sign ? -int'(fb.man) : int'(fb.man);
				e  = fb.exp;
				v  = (e < 0) ? (mx >>> (-e)) : (mx << e);
			end
			default:  v = '0;  // Illegal opcode
		endcase
		if (norm)
			v = normalize(v);
		r.value   = v;
		r.is_zero = (v == '0);
		return r;
	endfunction

	// ************************************************************************
	// Expected output register and checks
	// ************************************************************************

	always @(posedge clk) begin
		expect_t e;
		if (!rst_n) begin
			exp_valid <= 1'b0;
			exp_res   <= '0;
		end else if (exp_q.size() > 0) begin
			e = exp_q.pop_front();
			exp_valid <= e.valid;
			if (e.valid)
				exp_res <= e.res;  // Output holds when idle
		end else begin
			exp_valid <= 1'b0;
		end
	end

	task automatic report_mismatch(input string name, input word_t got, input word_t want);
		errors++;
		$display("mismatch at %0t: %s got %h, expected %h", $time, name, got, want);
	endtask

	assert property (@(posedge clk) disable iff (!rst_n) out_valid == exp_valid)
		else report_mismatch("out_valid", word_t'($sampled(out_valid)),
			word_t'($sampled(exp_valid)));
	assert property (@(posedge clk) disable iff (!rst_n) res.value == exp_res.value)
		else report_mismatch("res.value", $sampled(res.value), $sampled(exp_res.value));
	assert property (@(posedge clk) disable iff (!rst_n) res.is_zero == exp_res.is_zero)
		else report_mismatch("res.is_zero", word_t'($sampled(res.is_zero)),
			word_t'($sampled(exp_res.is_zero)));

	// ************************************************************************
	// Stimulus
	// ************************************************************************

	task automatic step(input logic valid, input alu_op_e op, input word_t a, input word_t b);
		@(posedge clk);
		#5;
		in_valid = valid;
		req      = '{op: op, a: a, b: b};
		exp_q.push_back({valid, ref_result(op, a, b)});
	endtask

	function automatic word_t rand_word();
		case ($urandom % 4)
			0:       return '0;
			1:       return word_t'(int'($urandom % 201) - 100);
			default: return $urandom;
		endcase
	endfunction

	function automatic word_t rand_divisor();
		int d;
		d = int'(1 + $urandom % 1000);
		return ($urandom % 2) ? word_t'(-d) : word_t'(d);
	endfunction

	// Exponent drawn from -span to span-1
	function automatic word_t rand_flt(input int span);
		flt_t f;
		f.sign = $urandom % 2;
		f.exp  = exp_t'(int'($urandom % (2 * span)) - span);
		f.man  = man_t'($urandom);
		return f;
	endfunction

	task automatic run_random(input alu_op_e op);
		word_t a;
		word_t b;
		for (int i = 0; i < REPS; i++) begin
			a = rand_word();
			b = rand_word();
			case (op)
				OP_DIV, OP_MOD:         b = rand_divisor();
				OP_SHL, OP_SHR, OP_SRS: b = $urandom % 40;  // Some past the word width
				OP_I2F:                 b = (i == 0) ? '0 :
					word_t'(int'($urandom % ((1 << 23) - 1)) - ((1 << 22) - 1));
				OP_F2I:                 b = rand_flt(32);
				OP_F_ADD, OP_F_MLT, OP_F_LES, OP_F_GRE: begin
					a = rand_flt((i % 3 == 0) ? 128 : 8);
					b = rand_flt(8);
				end
				default: ;
			endcase
			if (op inside {OP_EQU, OP_LES, OP_GRE, OP_F_LES, OP_F_GRE} && i % 4 == 0)
				b = a;
			if (op == OP_F_ADD && i % 4 == 1)
				b = {~a[WORD_W-1], a[WORD_W-2:0]};  // Sum cancels to a zero mantissa
			step(1'b1, op, a, b);
		end
	endtask

	// Two idle cycles let the last result reach its check
	task automatic finish_test(input string name);
		int n;
		step(1'b0, OP_NOP, '0, '0);
		step(1'b0, OP_NOP, '0, '0);
		n        = errors - err_base;
		err_base = errors;
		tests_run++;
		if (n > 0)
			tests_failed++;
		$display("test %-20s %s (%0d mismatches)", name, (n > 0) ? "FAIL" : "pass", n);
	endtask

	initial begin
		void'($urandom(7));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		req      = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst_n = 1'b1;

		step(1'b0, OP_NOP, '0, '0);  // Output must stay idle and zero
		step(1'b0, OP_NOP, '0, '0);
		step(1'b1, OP_LOD, 32'h1234_5678, 32'h0);
		step(1'b1, OP_NOP, 32'h0, 32'hdead_beef);
		finish_test("reset_latency");

		foreach (int_ops[i])
			run_random(int_ops[i]);
		finish_test("int_arith");

		foreach (bit_ops[i])
			run_random(bit_ops[i]);
		finish_test("bit_logic_shift");

		foreach (fun_ops[i])
			run_random(fun_ops[i]);
		finish_test("float_unary_i2f");

		foreach (far_ops[i])
			run_random(far_ops[i]);
		finish_test("float_arith_f2i");

		// Illegal opcodes interleaved with legal ones, no gaps
		foreach (illegal_codes[i]) begin
			step(1'b1, alu_op_e'(illegal_codes[i]), rand_word(), rand_word());
			step(1'b1, OP_ADD, rand_word(), rand_word());
		end
		finish_test("stream_illegal");

		$display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: filelist.f
alu_cfg_pkg.sv
alu_op_pkg.sv
int_unit.sv
float_unit.sv
result_stage.sv
alu_top.sv
tb_alu.sv

// File: Bender.yml
package:
  name: alu_unit

sources:
  # Packages first, then the units and the top level
  - alu_cfg_pkg.sv
  - alu_op_pkg.sv
  - int_unit.sv
  - float_unit.sv
  - result_stage.sv
  - alu_top.sv

  # Testbench, top module tb_alu
  - target: simulation
    files:
      - tb_alu.sv
